/* rtl/mcu_link_consts.svh */
`ifndef MCU_LINK_CONSTS_SVH
`define MCU_LINK_CONSTS_SVH

// link framing
`define MCU_BYTE_W       8      // bits per byte on the link
`define MCU_FRAME_BITS   16     // payload bits after the start bit

// scratch memory
`define MCU_MEM_DEPTH    256    // one byte per address, full 8-bit pointer range

// clock crossing
`define MCU_SYNC_STAGES  2      // flops per level synchronizer, at least 2

// reply bytes
`define MCU_REPLY_TAG    8'h12  // first byte of an echo reply
`define MCU_REPLY_PAD    8'h00  // second byte of a read reply

`endif

/* rtl/link_pkg.sv */
`include "mcu_link_consts.svh"

package link_pkg;

  // one data byte, opcode and operand alike
  typedef logic [`MCU_BYTE_W-1:0] byte_t;

  // bit position inside a frame, must reach MCU_FRAME_BITS
  typedef logic [4:0] frame_cnt_t;

  // reply serializer phases
  typedef enum logic [1:0] {
    LS_IDLE  = 2'd0,  // line low, waiting for a request
    LS_START = 2'd1,  // start bit on the line
    LS_SHIFT = 2'd2   // payload bits going out
  } link_state_e;

endpackage

/* rtl/cmd_pkg.sv */
`include "mcu_link_consts.svh"

package cmd_pkg;

  // host opcodes, everything else completes without effect
  typedef enum logic [`MCU_BYTE_W-1:0] {
    OP_NONE      = 8'h00,  // no command, dropped before execution
    OP_SET_ADDR  = 8'h01,  // pointer <= operand
    OP_WRITE_MEM = 8'h02,  // mem[pointer] <= operand
    OP_READ_MEM  = 8'h03,  // reply mem[operand], pad
    OP_ECHO      = 8'h30   // reply tag, operand
  } opcode_e;

  // executor phases
  typedef enum logic [1:0] {
    EX_IDLE       = 2'd0,  // waiting for cmd_valid
    EX_RUN        = 2'd1,  // cmd_done high, command retiring
    EX_WAIT_REPLY = 2'd2   // reply needed but previous one still in flight
  } exec_state_e;

endpackage

/* rtl/link_rx.sv */
`timescale 1ns/1ps
`include "mcu_link_consts.svh"

module link_rx import link_pkg::*; (
  input  logic  link_clk,
  input  logic  sys_rst_n,
  input  logic  link_in,     // serial data from host
  input  logic  rx_ack,      // from sys_clk domain
  output logic  rx_req,      // frame held, level
  output byte_t rx_opcode,
  output byte_t rx_operand
);

  logic [`MCU_SYNC_STAGES-1:0] ack_sync;  // rx_ack into link_clk
  logic                        ack_s;
  frame_cnt_t                  bit_cnt;   // 0 means hunting for a start bit
  logic                        shift_en;

  assign ack_s    = ack_sync[`MCU_SYNC_STAGES-1];
  assign shift_en = (bit_cnt != '0);  // every edge after the start bit samples data

  // frame control and handshake
  always_ff @(posedge link_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      ack_sync <= '0;
      bit_cnt  <= '0;
      rx_req   <= 1'b0;
    end else begin
      ack_sync <= {ack_sync[`MCU_SYNC_STAGES-2:0], rx_ack};

      // sys side has the frame, release it
      if (rx_req && ack_s) begin
        rx_req <= 1'b0;
      end

      if (bit_cnt == '0) begin
        // start bits are ignored while the last frame is still held
        if (!rx_req && link_in) begin
          bit_cnt <= 5'd1;
        end
      end else if (bit_cnt == `MCU_FRAME_BITS) begin
        bit_cnt <= '0;   // last operand bit sampled on this edge
        rx_req  <= 1'b1;
      end else begin
        bit_cnt <= bit_cnt + 1'b1;
      end
    end
  end

  // lsb first, so shift in from the top of the operand toward opcode bit 0
  always_ff @(posedge link_clk) begin
    if (shift_en) begin
      {rx_operand, rx_opcode} <= {link_in, rx_operand, rx_opcode[`MCU_BYTE_W-1:1]};
    end
  end

endmodule

/* rtl/cmd_sync.sv */
`timescale 1ns/1ps
`include "mcu_link_consts.svh"

module cmd_sync import link_pkg::*, cmd_pkg::*; (
  input  logic    sys_clk,
  input  logic    sys_rst_n,
  input  logic    rx_req,       // from link_clk domain
  input  byte_t   rx_opcode,    // stable while rx_req high
  input  byte_t   rx_operand,
  input  logic    cmd_done,     // one cycle pulse from executor
  output logic    rx_ack,
  output logic    cmd_valid,
  output opcode_e cmd_opcode,
  output byte_t   cmd_operand,
  output logic    busy
);

  logic [`MCU_SYNC_STAGES-1:0] req_sync;  // rx_req into sys_clk
  logic                        req_s;
  logic                        capture;

  assign req_s   = req_sync[`MCU_SYNC_STAGES-1];
  assign capture = req_s && !rx_ack && !cmd_valid;  // one command at a time
  assign busy    = cmd_valid && !cmd_done;

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      req_sync  <= '0;
      rx_ack    <= 1'b0;
      cmd_valid <= 1'b0;
    end else begin
      req_sync <= {req_sync[`MCU_SYNC_STAGES-2:0], rx_req};

      if (!req_s) begin
        rx_ack <= 1'b0;  // link side let go, close the handshake
      end else if (capture) begin
        rx_ack    <= 1'b1;
        cmd_valid <= (rx_opcode != OP_NONE);  // empty frames only get acked
      end

      if (cmd_done) begin
        cmd_valid <= 1'b0;
      end
    end
  end

  // frame bytes are quiet by the time req_s is seen
  always_ff @(posedge sys_clk) begin
    if (capture) begin
      cmd_opcode  <= opcode_e'(rx_opcode);
      cmd_operand <= rx_operand;
    end
  end

endmodule

/* rtl/cmd_exec.sv */
`timescale 1ns/1ps
`include "mcu_link_consts.svh"

module cmd_exec import link_pkg::*, cmd_pkg::*; (
  input  logic    sys_clk,
  input  logic    sys_rst_n,
  input  logic    cmd_valid,
  input  opcode_e cmd_opcode,
  input  byte_t   cmd_operand,
  input  logic    tx_ack,     // from link_clk domain
  output logic    cmd_done,
  output logic    tx_req,
  output byte_t   tx_byte0,
  output byte_t   tx_byte1
);

  byte_t                       mem [`MCU_MEM_DEPTH];  // scratch memory
  byte_t                       addr_ptr;
  exec_state_e                 state;
  logic [`MCU_SYNC_STAGES-1:0] ack_sync;  // tx_ack into sys_clk
  logic                        ack_s;
  logic                        reply_busy;
  logic                        is_reply;
  logic                        go;

  assign ack_s = ack_sync[`MCU_SYNC_STAGES-1];

  // serializer owns the reply until both levels are low again
  assign reply_busy = tx_req || ack_s;

  assign is_reply = (cmd_opcode == OP_READ_MEM) || (cmd_opcode == OP_ECHO);

  // command retires on this edge
  always_comb begin
    go = 1'b0;
    if (cmd_valid) begin
      case (state)
        EX_IDLE:       go = !(is_reply && reply_busy);
        EX_WAIT_REPLY: go = !reply_busy;
        default:       go = 1'b0;  // EX_RUN, cmd_valid is about to drop
      endcase
    end
  end

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      state    <= EX_IDLE;
      cmd_done <= 1'b0;
      tx_req   <= 1'b0;
      addr_ptr <= '0;
      ack_sync <= '0;
    end else begin
      ack_sync <= {ack_sync[`MCU_SYNC_STAGES-2:0], tx_ack};

      if (tx_req && ack_s) begin
        tx_req <= 1'b0;  // reply went out
      end

      case (state)
        EX_IDLE: begin
          if (cmd_valid && !go) begin
            state <= EX_WAIT_REPLY;
          end
        end
        EX_RUN: begin
          cmd_done <= 1'b0;  // single cycle pulse
          state    <= EX_IDLE;
        end
        default: ;  // EX_WAIT_REPLY leaves through go below
      endcase

      if (go) begin
        cmd_done <= 1'b1;
        state    <= EX_RUN;
        case (cmd_opcode)
          OP_SET_ADDR: addr_ptr <= cmd_operand;
          OP_READ_MEM: tx_req   <= 1'b1;
          OP_ECHO:     tx_req   <= 1'b1;
          default:     ;  // write handled below, unknown opcodes just retire
        endcase
      end
    end
  end

  // cleared so unwritten locations read back as zero
  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      for (int i = 0; i < `MCU_MEM_DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else if (go && (cmd_opcode == OP_WRITE_MEM)) begin
      mem[addr_ptr] <= cmd_operand;
    end
  end

  // reply bytes, loaded with tx_req and held while it is high
  always_ff @(posedge sys_clk) begin
    if (go) begin
      if (cmd_opcode == OP_READ_MEM) begin
        tx_byte0 <= mem[cmd_operand];  // address from operand, not the pointer
        tx_byte1 <= `MCU_REPLY_PAD;
      end else if (cmd_opcode == OP_ECHO) begin
        tx_byte0 <= `MCU_REPLY_TAG;
        tx_byte1 <= cmd_operand;
      end
    end
  end

endmodule

/* rtl/link_tx.sv */
`timescale 1ns/1ps
`include "mcu_link_consts.svh"

module link_tx import link_pkg::*; (
  input  logic  link_clk,
  input  logic  sys_rst_n,
  input  logic  tx_req,    // from sys_clk domain, level
  input  byte_t tx_byte0,  // sent first
  input  byte_t tx_byte1,
  output logic  tx_ack,
  output logic  link_out   // serial data to host
);

  logic [`MCU_SYNC_STAGES-1:0] req_sync;  // tx_req into link_clk
  logic                        req_s;
  link_state_e                 state;
  frame_cnt_t                  bit_cnt;
  logic [`MCU_FRAME_BITS-1:0]  frame;

  assign req_s = req_sync[`MCU_SYNC_STAGES-1];
  assign frame = {tx_byte1, tx_byte0};  // bit 0 is byte0 lsb

  always_ff @(posedge link_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      req_sync <= '0;
      state    <= LS_IDLE;
      bit_cnt  <= '0;
      tx_ack   <= 1'b0;
      link_out <= 1'b0;
    end else begin
      req_sync <= {req_sync[`MCU_SYNC_STAGES-2:0], tx_req};

      case (state)
        LS_IDLE: begin
          link_out <= 1'b0;
          if (tx_ack) begin
            // hold ack until the request is withdrawn
            if (!req_s) begin
              tx_ack <= 1'b0;
            end
          end else if (req_s) begin
            link_out <= 1'b1;  // start bit
            state    <= LS_START;
          end
        end
        LS_START: begin
          link_out <= frame[0];
          bit_cnt  <= 5'd1;
          state    <= LS_SHIFT;
        end
        LS_SHIFT: begin
          if (bit_cnt == `MCU_FRAME_BITS) begin
            link_out <= 1'b0;  // back to idle level after bit 15
            tx_ack   <= 1'b1;
            bit_cnt  <= '0;
            state    <= LS_IDLE;
          end else begin
            link_out <= frame[bit_cnt[3:0]];
            bit_cnt  <= bit_cnt + 1'b1;
          end
        end
        default: begin
          state <= LS_IDLE;
        end
      endcase
    end
  end

endmodule

/* rtl/mcu_link_top.sv */
`timescale 1ns/1ps

module mcu_link_top import link_pkg::*, cmd_pkg::*; (
  input  logic sys_clk,
  input  logic sys_rst_n,
  input  logic link_clk,   // from host
  input  logic link_in,    // from host
  output logic link_out,   // to host
  output logic busy
);

  // receiver to crossing
  logic    rx_req;
  logic    rx_ack;
  byte_t   rx_opcode;
  byte_t   rx_operand;

  // crossing to executor
  logic    cmd_valid;
  opcode_e cmd_opcode;
  byte_t   cmd_operand;
  logic    cmd_done;

  // executor to reply serializer
  logic    tx_req;
  logic    tx_ack;
  byte_t   tx_byte0;
  byte_t   tx_byte1;

  link_rx u_link_rx (
    .link_clk   (link_clk),
    .sys_rst_n  (sys_rst_n),
    .link_in    (link_in),
    .rx_ack     (rx_ack),
    .rx_req     (rx_req),
    .rx_opcode  (rx_opcode),
    .rx_operand (rx_operand)
  );

  cmd_sync u_cmd_sync (
    .sys_clk     (sys_clk),
    .sys_rst_n   (sys_rst_n),
    .rx_req      (rx_req),
    .rx_opcode   (rx_opcode),
    .rx_operand  (rx_operand),
    .cmd_done    (cmd_done),
    .rx_ack      (rx_ack),
    .cmd_valid   (cmd_valid),
    .cmd_opcode  (cmd_opcode),
    .cmd_operand (cmd_operand),
    .busy        (busy)
  );

  cmd_exec u_cmd_exec (
    .sys_clk     (sys_clk),
    .sys_rst_n   (sys_rst_n),
    .cmd_valid   (cmd_valid),
    .cmd_opcode  (cmd_opcode),
    .cmd_operand (cmd_operand),
    .tx_ack      (tx_ack),
    .cmd_done    (cmd_done),
    .tx_req      (tx_req),
    .tx_byte0    (tx_byte0),
    .tx_byte1    (tx_byte1)
  );

  link_tx u_link_tx (
    .link_clk  (link_clk),
    .sys_rst_n (sys_rst_n),
    .tx_req    (tx_req),
    .tx_byte0  (tx_byte0),
    .tx_byte1  (tx_byte1),
    .tx_ack    (tx_ack),
    .link_out  (link_out)
  );

endmodule

/* sim/tb_mcu_link.sv */
`timescale 1ns/1ps

module tb_mcu_link import cmd_pkg::*; ();

  logic sys_clk;
  logic sys_rst_n;
  logic link_clk;
  logic link_in;
  logic link_out;
  logic busy;

  logic [31:0] rnd_state;       // lcg state
  logic [7:0]  ref_mem [256];   // model of the scratch memory
  logic [7:0]  ref_ptr;         // model of the address pointer
  logic [15:0] exp_q [$];       // replies still owed, {byte1, byte0}
  logic [15:0] got_q [$];       // replies seen on link_out
  logic [7:0]  wr_addr_q [$];   // addresses touched by the random fill
  logic [15:0] shift_word;      // reply being collected
  int          rx_bits;         // 0 while hunting for a start bit

  always #50 sys_clk = ~sys_clk;
  always #150 link_clk = ~link_clk;  // host link, 3x slower

  mcu_link_top u_dut (
    .sys_clk   (sys_clk),
    .sys_rst_n (sys_rst_n),
    .link_clk  (link_clk),
    .link_in   (link_in),
    .link_out  (link_out),
    .busy      (busy)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic next_rand(output logic [7:0] val);
    rnd_state = lcg_next(rnd_state);
    val = rnd_state[23:16];  // upper bits have the longer period
  endtask

  // effect of one command on the model, reply as {byte1, byte0}
  function automatic logic [15:0] model_cmd(input logic [7:0] op, input logic [7:0] arg,
                                            output logic has_reply);
    logic [15:0] reply;
    reply = 16'h0000;
    has_reply = 1'b0;
    case (op)
      OP_SET_ADDR:  ref_ptr = arg;
      OP_WRITE_MEM: ref_mem[ref_ptr] = arg;
      OP_READ_MEM: begin
        reply = {8'h00, ref_mem[arg]};  // location named by the operand, then pad
        has_reply = 1'b1;
      end
      OP_ECHO: begin
        reply = {arg, 8'h12};  // tag first
        has_reply = 1'b1;
      end
      default: ;  // empty or unknown, no change and no reply
    endcase
    return reply;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Some tests failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_equal(input logic [15:0] got, input logic [15:0] exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("FAIL %0t ns: %s got %h expected %h", $time, what, got, exp));
    end
  endtask

  // start bit, opcode lsb first, then operand lsb first
  task automatic send_frame(input logic [7:0] op, input logic [7:0] arg);
    logic [15:0] payload;
    payload = {arg, op};
    check_equal(busy, 1'b0, "busy before frame");
    repeat (6) @(posedge link_clk) link_in <= 1'b0;  // idle gap, receiver drops its request
    @(posedge link_clk) link_in <= 1'b1;
    for (int i = 0; i < 16; i++) begin
      @(posedge link_clk) link_in <= payload[i];
    end
    @(posedge link_clk) link_in <= 1'b0;
  endtask

  task automatic wait_busy(input logic level, input int limit);
    int n;
    n = 0;
    do begin
      @(negedge sys_clk);
      n++;
    end while (busy !== level && n < limit);
    if (busy !== level) begin
      abort_run($sformatf("timed out waiting for busy to go %0d", level));
    end
  endtask

  task automatic wait_replies(input int limit);
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < limit) begin
      @(negedge link_clk);
      n++;
    end
    if (exp_q.size() != 0) begin
      abort_run("timed out waiting for a reply on link_out");
    end
  endtask

  // one host transaction, frame out and any reply back
  task automatic run_cmd(input logic [7:0] op, input logic [7:0] arg);
    logic [15:0] reply;
    logic        has_reply;
    reply = model_cmd(op, arg, has_reply);
    if (has_reply) begin
      exp_q.push_back(reply);
    end
    send_frame(op, arg);
    if (op != OP_NONE) begin
      wait_busy(1'b1, 40);   // capture comes a few sys_clk cycles after the last bit
      wait_busy(1'b0, 400);  // longer when a reply is still draining
    end else begin
      // empty frame is acked only, busy never rises
      for (int i = 0; i < 30; i++) begin
        @(negedge sys_clk);
        check_equal(busy, 1'b0, "busy on empty frame");
      end
    end
    wait_replies(100);
  endtask

  // reply collector, link_out is settled at the falling edge
  always @(negedge link_clk) begin
    if (rx_bits == 0) begin
      if (link_out === 1'b1) begin
        rx_bits = 1;
      end
    end else begin
      shift_word = {link_out, shift_word[15:1]};  // lsb first
      if (rx_bits == 16) begin
        got_q.push_back(shift_word);
        rx_bits = 0;
      end else begin
        rx_bits++;
      end
    end
  end

  // compares on the other edge so the collector has settled
  always @(posedge link_clk) begin
    if (got_q.size() != 0) begin
      if (exp_q.size() == 0) begin
        abort_run("a reply arrived on link_out when none was expected");
      end else begin
        check_equal(got_q.pop_front(), exp_q.pop_front(), "reply {byte1, byte0}");
      end
    end
  end

  initial begin
    logic [7:0] addr;
    logic [7:0] data;
    sys_clk    = 1'b0;
    link_clk   = 1'b0;
    sys_rst_n  = 1'b0;
    link_in    = 1'b0;
    rnd_state  = 32'h2811_3a0e;
    ref_ptr    = 8'h00;
    rx_bits    = 0;
    shift_word = 16'h0000;
    for (int i = 0; i < 256; i++) begin
      ref_mem[i] = 8'h00;  // memory clears on reset
    end
    repeat (8) @(posedge sys_clk);
    sys_rst_n <= 1'b1;

    // quiet after reset
    for (int i = 0; i < 20; i++) begin
      @(negedge sys_clk);
      check_equal(link_out, 1'b0, "link_out after reset");
      check_equal(busy, 1'b0, "busy after reset");
    end

    next_rand(data);
    run_cmd(OP_ECHO, data);

    // single write and read back
    next_rand(addr);
    next_rand(data);
    run_cmd(OP_SET_ADDR, addr);
    run_cmd(OP_WRITE_MEM, data);
    run_cmd(OP_READ_MEM, addr);

    for (int i = 0; i < 40; i++) begin
      next_rand(addr);
      next_rand(data);
      wr_addr_q.push_back(addr);
      run_cmd(OP_SET_ADDR, addr);
      run_cmd(OP_WRITE_MEM, data);
    end
    for (int i = 0; i < 20; i++) begin
      next_rand(addr);  // mostly unwritten locations
      run_cmd(OP_READ_MEM, addr);
    end
    for (int i = 0; i < wr_addr_q.size(); i++) begin
      run_cmd(OP_READ_MEM, wr_addr_q[i]);
    end

    // unknown and empty frames, link must still work after
    run_cmd(8'h55, 8'ha5);
    run_cmd(OP_NONE, 8'h3c);
    next_rand(data);
    run_cmd(OP_ECHO, data);

    repeat (40) @(negedge link_clk);  // room for any stray reply
    if (exp_q.size() == 0 && got_q.size() == 0) begin
      $display("All tests passed");
      $finish;
    end else begin
      abort_run("replies were left over at the end of the run");
    end
  end

endmodule

/* tb.f */
+incdir+rtl
rtl/link_pkg.sv
rtl/cmd_pkg.sv
rtl/link_rx.sv
rtl/cmd_sync.sv
rtl/cmd_exec.sv
rtl/link_tx.sv
rtl/mcu_link_top.sv
sim/tb_mcu_link.sv

/* Bender.yml */
package:
  name: mcu_link

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/link_pkg.sv
      - rtl/cmd_pkg.sv
      - rtl/link_rx.sv
      - rtl/cmd_sync.sv
      - rtl/cmd_exec.sv
      - rtl/link_tx.sv
      - rtl/mcu_link_top.sv
  - target: simulation
    files:
      - sim/tb_mcu_link.sv
